/* src/cache_csr_apb.sv */
`include "cache_macros.svh"

module cache_csr_apb
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  csr_addr_t paddr_i,
    input  word_t     pwdata_i,
    output word_t     prdata_o,

    input  logic      hit_i,
    input  logic      miss_i,
    input  logic      writeback_i,

    output logic      bypass_o
);

    localparam int NUM_COUNTERS = 3;

    logic                    apb_write;
    logic [NUM_COUNTERS-1:0] cnt_event;
    logic [NUM_COUNTERS-1:0] cnt_clear;
    count_t                  cnt_q [NUM_COUNTERS];

    assign apb_write = psel_i && penable_i && pwrite_i;

    // Counter slots are hits, misses and write-backs in that order
    assign cnt_event    = {writeback_i, miss_i, hit_i};
    assign cnt_clear[0] = apb_write && (paddr_i == `CSR_HITS);
    assign cnt_clear[1] = apb_write && (paddr_i == `CSR_MISSES);
    assign cnt_clear[2] = apb_write && (paddr_i == `CSR_WRITEBACKS);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            bypass_o <= 1'b0;
            for (int i = 0; i < NUM_COUNTERS; i++)
                cnt_q[i] <= '0;
        end
        else
        begin
            if (apb_write && (paddr_i == `CSR_CTRL))
                bypass_o <= pwdata_i[0];
            // A clear beats an event in the same cycle
            for (int i = 0; i < NUM_COUNTERS; i++)
            begin
                if (cnt_clear[i])
                    cnt_q[i] <= '0;
                else if (cnt_event[i])
                    cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    always_comb
    begin
        unique case (paddr_i)
            `CSR_CTRL:       prdata_o = {{(`CACHE_DATA_WIDTH-1){1'b0}}, bypass_o};
            `CSR_HITS:       prdata_o = cnt_q[0];
            `CSR_MISSES:     prdata_o = cnt_q[1];
            `CSR_WRITEBACKS: prdata_o = cnt_q[2];
            default:         prdata_o = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n) penable_i |-> (psel_i && $past(psel_i)))
        else $error("APB access phase without a preceding setup phase");

endmodule

/* src/cache_ctrl_fsm.sv */
`include "cache_macros.svh"

module cache_ctrl_fsm
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    input  logic   proc_req_i,
    input  addr_t  proc_addr_i,
    input  logic   proc_we_i,
    input  be_t    proc_be_i,
    input  word_t  proc_wdata_i,
    output logic   proc_gnt_o,
    output logic   proc_rvalid_o,
    output word_t  proc_rdata_o,

    output logic   mem_req_o,
    output addr_t  mem_addr_o,
    output logic   mem_we_o,
    output be_t    mem_be_o,
    output word_t  mem_wdata_o,
    input  logic   mem_gnt_i,
    input  logic   mem_rvalid_i,
    input  word_t  mem_rdata_i,

    input  logic   bypass_i,

    input  logic   line_hit_i,
    input  logic   line_dirty_i,
    input  tag_t   victim_tag_i,
    input  word_t  line_data_i,
    output index_t index_o,
    output tag_t   tag_o,
    output logic   line_write_o,
    output logic   line_fill_o,
    output be_t    line_be_o,
    output word_t  line_wdata_o,
    output word_t  fill_data_o,

    output logic   hit_o,
    output logic   miss_o,
    output logic   writeback_o
);

    ctrl_state_t state_q;
    addr_t       req_addr_q;
    logic        req_we_q;
    be_t         req_be_q;
    word_t       req_wdata_q;
    addr_t       fill_addr;

    assign index_o   = req_addr_q[`CACHE_INDEX_WIDTH+1:2];
    assign tag_o     = req_addr_q[`CACHE_ADDR_WIDTH-1:`CACHE_ADDR_WIDTH-`CACHE_TAG_WIDTH];
    assign fill_addr = {tag_o, index_o, 2'b00};

    assign hit_o       = (state_q == LOOKUP) && line_hit_i;
    assign miss_o      = (state_q == LOOKUP) && !line_hit_i;
    assign writeback_o = (state_q == WB_RESP) && mem_rvalid_i;

    // Store hits write in LOOKUP and store misses merge during the refill
    assign line_fill_o  = (state_q == FILL_RESP) && mem_rvalid_i;
    assign line_write_o = req_we_q && (hit_o || line_fill_o);
    assign line_be_o    = req_be_q;
    assign line_wdata_o = req_wdata_q;
    assign fill_data_o  = mem_rdata_i;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q       <= IDLE;
            proc_gnt_o    <= 1'b0;
            proc_rvalid_o <= 1'b0;
            mem_req_o     <= 1'b0;
        end
        else
        begin
            proc_gnt_o    <= 1'b0;
            proc_rvalid_o <= 1'b0;
            unique case (state_q)
                IDLE:
                begin
                    if (proc_req_i)
                    begin
                        req_addr_q  <= proc_addr_i;
                        req_we_q    <= proc_we_i;
                        req_be_q    <= proc_be_i;
                        req_wdata_q <= proc_wdata_i;
                        if (bypass_i)
                        begin
                            mem_req_o   <= 1'b1;
                            mem_addr_o  <= proc_addr_i;
                            mem_we_o    <= proc_we_i;
                            mem_be_o    <= proc_be_i;
                            mem_wdata_o <= proc_wdata_i;
                            state_q     <= BYPASS_REQ;
                        end
                        else
                        begin
                            proc_gnt_o <= 1'b1;
                            state_q    <= LOOKUP;
                        end
                    end
                end
                LOOKUP:
                begin
                    if (line_hit_i)
                    begin
                        proc_rvalid_o <= 1'b1;
                        proc_rdata_o  <= req_we_q ? '0 : line_data_i;
                        state_q       <= HIT_DATA;
                    end
                    else if (line_dirty_i)
                    begin
                        mem_req_o   <= 1'b1;
                        mem_addr_o  <= {victim_tag_i, index_o, 2'b00};
                        mem_we_o    <= 1'b1;
                        mem_be_o    <= '1;
                        mem_wdata_o <= line_data_i;
                        state_q     <= WB_REQ;
                    end
                    else
                    begin
                        mem_req_o   <= 1'b1;
                        mem_addr_o  <= fill_addr;
                        mem_we_o    <= 1'b0;
                        mem_be_o    <= '1;
                        mem_wdata_o <= '0;
                        state_q     <= FILL_REQ;
                    end
                end
                HIT_DATA:
                begin
                    state_q <= IDLE;
                end
                WB_REQ:
                begin
                    if (mem_gnt_i)
                    begin
                        mem_req_o <= 1'b0;
                        state_q   <= WB_RESP;
                    end
                end
                WB_RESP:
                begin
                    if (mem_rvalid_i)
                    begin
                        mem_req_o   <= 1'b1;
                        mem_addr_o  <= fill_addr;
                        mem_we_o    <= 1'b0;
                        mem_be_o    <= '1;
                        mem_wdata_o <= '0;
                        state_q     <= FILL_REQ;
                    end
                end
                FILL_REQ:
                begin
                    if (mem_gnt_i)
                    begin
                        mem_req_o <= 1'b0;
                        state_q   <= FILL_RESP;
                    end
                end
                FILL_RESP:
                begin
                    if (mem_rvalid_i)
                    begin
                        proc_rvalid_o <= 1'b1;
                        proc_rdata_o  <= req_we_q ? '0 : mem_rdata_i;
                        state_q       <= HIT_DATA;
                    end
                end
                BYPASS_REQ:
                begin
                    if (mem_gnt_i)
                    begin
                        mem_req_o  <= 1'b0;
                        proc_gnt_o <= 1'b1;
                        state_q    <= BYPASS_RESP;
                    end
                end
                BYPASS_RESP:
                begin
                    if (mem_rvalid_i)
                    begin
                        proc_rvalid_o <= 1'b1;
                        proc_rdata_o  <= req_we_q ? '0 : mem_rdata_i;
                        state_q       <= IDLE;
                    end
                end
                default:
                begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(proc_gnt_o && proc_rvalid_o))
        else $error("Grant and response to the processor in the same cycle");

    // Memory requests are held with stable fields until the memory grants them
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o)
            && $stable(mem_be_o) && $stable(mem_wdata_o)))
        else $error("Memory request dropped or changed before its grant");

endmodule

/* src/cache_line_store.sv */
`include "cache_macros.svh"

module cache_line_store
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    input  index_t index_i,
    input  tag_t   tag_i,
    output logic   hit_o,
    output logic   dirty_o,
    output tag_t   victim_tag_o,
    output word_t  line_data_o,

    input  logic   write_i,
    input  logic   fill_i,
    input  be_t    be_i,
    input  word_t  wdata_i,
    input  word_t  fill_data_i
);

    localparam int BYTES = `CACHE_DATA_WIDTH / 8;

    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;
    tag_t                    tag_q [`CACHE_LINES];
    word_t                   data_q [`CACHE_LINES];
    word_t                   base_word;
    word_t                   merged_word;

    assign hit_o        = valid_q[index_i] && (tag_q[index_i] == tag_i);
    assign dirty_o      = valid_q[index_i] && dirty_q[index_i];
    assign victim_tag_o = tag_q[index_i];
    assign line_data_o  = data_q[index_i];

    // A store during a refill lands on top of the fetched word
    assign base_word = fill_i ? fill_data_i : data_q[index_i];

    always_comb
    begin
        merged_word = base_word;
        for (int b = 0; b < BYTES; b++)
        begin
            if (write_i && be_i[b])
                merged_word[8*b +: 8] = wdata_i[8*b +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (fill_i)
        begin
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= write_i;
        end
        else if (write_i)
        begin
            dirty_q[index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_i)
            tag_q[index_i] <= tag_i;
        if (fill_i || write_i)
            data_q[index_i] <= merged_word;
    end

    // The controller only writes a line it hit on or is refilling
    assert property (@(posedge clk) disable iff (!rst_n) write_i |-> (hit_o || fill_i))
        else $error("Line write without a hit or a fill");

endmodule

/* src/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Address and data widths of the processor and memory ports
`define CACHE_ADDR_WIDTH    16
`define CACHE_DATA_WIDTH    32

// Direct-mapped geometry with one word per line
`define CACHE_LINES         16
`define CACHE_INDEX_WIDTH   4
`define CACHE_TAG_WIDTH     10

// Register block address map
`define CSR_ADDR_WIDTH      8
`define CSR_CTRL            8'h00
`define CSR_HITS            8'h04
`define CSR_MISSES          8'h08
`define CSR_WRITEBACKS      8'h0C

`endif

/* src/cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_WIDTH-1:0]     addr_t;
    typedef logic [`CACHE_DATA_WIDTH-1:0]     word_t;
    typedef logic [`CACHE_DATA_WIDTH/8-1:0]   be_t;
    typedef logic [`CACHE_INDEX_WIDTH-1:0]    index_t;
    typedef logic [`CACHE_TAG_WIDTH-1:0]      tag_t;
    typedef logic [31:0]                      count_t;
    typedef logic [`CSR_ADDR_WIDTH-1:0]       csr_addr_t;

    typedef enum logic [3:0]
    {
        IDLE,
        LOOKUP,
        HIT_DATA,
        WB_REQ,
        WB_RESP,
        FILL_REQ,
        FILL_RESP,
        BYPASS_REQ,
        BYPASS_RESP
    } ctrl_state_t;

endpackage

/* src/dcache_top.sv */
module dcache_top
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      proc_req_i,
    input  addr_t     proc_addr_i,
    input  logic      proc_we_i,
    input  be_t       proc_be_i,
    input  word_t     proc_wdata_i,
    output logic      proc_gnt_o,
    output logic      proc_rvalid_o,
    output word_t     proc_rdata_o,

    output logic      mem_req_o,
    output addr_t     mem_addr_o,
    output logic      mem_we_o,
    output be_t       mem_be_o,
    output word_t     mem_wdata_o,
    input  logic      mem_gnt_i,
    input  logic      mem_rvalid_i,
    input  word_t     mem_rdata_i,

    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  csr_addr_t paddr_i,
    input  word_t     pwdata_i,
    output word_t     prdata_o
);

    logic   bypass;
    logic   ev_hit;
    logic   ev_miss;
    logic   ev_writeback;
    index_t line_index;
    tag_t   line_tag;
    logic   line_hit;
    logic   line_dirty;
    tag_t   victim_tag;
    word_t  line_data;
    logic   line_write;
    logic   line_fill;
    be_t    line_be;
    word_t  line_wdata;
    word_t  fill_data;

    // Processor and memory ports connect by name
    cache_ctrl_fsm ctrl_i (
        .bypass_i     (bypass),
        .line_hit_i   (line_hit),
        .line_dirty_i (line_dirty),
        .victim_tag_i (victim_tag),
        .line_data_i  (line_data),
        .index_o      (line_index),
        .tag_o        (line_tag),
        .line_write_o (line_write),
        .line_fill_o  (line_fill),
        .line_be_o    (line_be),
        .line_wdata_o (line_wdata),
        .fill_data_o  (fill_data),
        .hit_o        (ev_hit),
        .miss_o       (ev_miss),
        .writeback_o  (ev_writeback),
        .*
    );

    cache_line_store store_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .index_i      (line_index),
        .tag_i        (line_tag),
        .hit_o        (line_hit),
        .dirty_o      (line_dirty),
        .victim_tag_o (victim_tag),
        .line_data_o  (line_data),
        .write_i      (line_write),
        .fill_i       (line_fill),
        .be_i         (line_be),
        .wdata_i      (line_wdata),
        .fill_data_i  (fill_data)
    );

    cache_csr_apb csr_i (
        .hit_i        (ev_hit),
        .miss_i       (ev_miss),
        .writeback_i  (ev_writeback),
        .bypass_o     (bypass),
        .*
    );

endmodule

/* tb/tb_dcache_top.sv */
`include "cache_macros.svh"

module tb_dcache_top
    import cache_pkg::*;
();

    // About ten times the length of the directed sequence below
    localparam int MAX_CYCLES = 4000;

    logic      clk;
    logic      rst_n;
    logic      proc_req_i;
    addr_t     proc_addr_i;
    logic      proc_we_i;
    be_t       proc_be_i;
    word_t     proc_wdata_i;
    logic      proc_gnt_o;
    logic      proc_rvalid_o;
    word_t     proc_rdata_o;
    logic      mem_req_o;
    addr_t     mem_addr_o;
    logic      mem_we_o;
    be_t       mem_be_o;
    word_t     mem_wdata_o;
    logic      mem_gnt_i;
    logic      mem_rvalid_i;
    word_t     mem_rdata_i;
    logic      psel_i;
    logic      penable_i;
    logic      pwrite_i;
    csr_addr_t paddr_i;
    word_t     pwdata_i;
    word_t     prdata_o;

    int         errors;
    int         cycles;
    int         mem_reads;
    int         mem_writes;
    int         delay;
    int         k;
    logic [15:0] lfsr;
    logic [5:0] m_idx;
    word_t      m_rdata;
    addr_t      last_wr_addr;
    word_t      mem_model [64];
    word_t      ref_mem [64];
    word_t      exp_rdata;
    logic       expect_hit;
    logic       bypass_mode;

    dcache_top dut_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic word_t fill_word(input logic [5:0] w);
        return {8'hA5 ^ {2'b00, w}, 8'h3C + {2'b00, w}, ~{2'b00, w}, {2'b11, w}};
    endfunction

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input be_t be);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    // Taps 16, 14, 13 and 11 with one step per bit taken
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val = (val << 1) | lfsr[0];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic run_access(input addr_t addr, input logic we, input be_t be,
                              input word_t wdata, input logic hit,
                              input int exp_writes, input int exp_reads);
        int         writes0;
        int         reads0;
        logic [5:0] w;
        writes0 = mem_writes;
        reads0 = mem_reads;
        w = addr[7:2];
        exp_rdata = we ? '0 : ref_mem[w];
        expect_hit = hit;
        proc_req_i = 1'b1;
        proc_addr_i = addr;
        proc_we_i = we;
        proc_be_i = be;
        proc_wdata_i = wdata;
        do @(posedge clk); while (!proc_gnt_o);
        #1 proc_req_i = 1'b0;
        do @(posedge clk); while (!proc_rvalid_o);
        #1;
        if (we)
            ref_mem[w] = merge_bytes(ref_mem[w], wdata, be);
        if ((mem_writes - writes0 != exp_writes) || (mem_reads - reads0 != exp_reads))
        begin
            errors++;
            $display("Access to %h made %0d memory writes and %0d reads instead of %0d and %0d",
                     addr, mem_writes - writes0, mem_reads - reads0, exp_writes, exp_reads);
        end
    endtask

    task automatic apb_write(input csr_addr_t addr, input word_t data);
        psel_i = 1'b1;
        penable_i = 1'b0;
        pwrite_i = 1'b1;
        paddr_i = addr;
        pwdata_i = data;
        @(posedge clk);
        #1 penable_i = 1'b1;
        @(posedge clk);
        #1 psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
    endtask

    task automatic check_csr(input csr_addr_t addr, input word_t exp);
        word_t got;
        psel_i = 1'b1;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = addr;
        @(posedge clk);
        #1 penable_i = 1'b1;
        @(posedge clk);
        got = prdata_o;
        #1 psel_i = 1'b0;
        penable_i = 1'b0;
        if (got !== exp)
            report_mismatch($sformatf("prdata_o at offset %h", addr), exp, got);
    endtask

    task automatic check_mem_word(input addr_t addr);
        if (mem_model[addr[7:2]] !== ref_mem[addr[7:2]])
            report_mismatch($sformatf("mem_wdata_o written to %h", addr),
                            ref_mem[addr[7:2]], mem_model[addr[7:2]]);
    endtask

    // Memory model with random grant and response latency
    always
    begin
        @(posedge clk);
        if (rst_n && mem_req_o)
        begin
            draw_bits(2, delay);
            repeat (delay % 3) @(posedge clk);
            #1 mem_gnt_i = 1'b1;
            @(posedge clk);
            m_idx = mem_addr_o[7:2];
            if (mem_we_o)
            begin
                mem_model[m_idx] = merge_bytes(mem_model[m_idx], mem_wdata_o, mem_be_o);
                m_rdata = '0;
                last_wr_addr = mem_addr_o;
                mem_writes++;
            end
            else
            begin
                m_rdata = mem_model[m_idx];
                mem_reads++;
            end
            #1 mem_gnt_i = 1'b0;
            draw_bits(2, delay);
            for (k = 0; k < delay % 3; k++)
            begin
                @(posedge clk);
                #1;
            end
            mem_rvalid_i = 1'b1;
            mem_rdata_i = m_rdata;
            @(posedge clk);
            #1 mem_rvalid_i = 1'b0;
            mem_rdata_i = '0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (expect_hit && $rose(proc_req_i)) |=> (proc_gnt_o && !mem_req_o)
            ##1 (proc_rvalid_o && !mem_req_o))
        else begin
            errors++;
            $display("A cache hit was not granted and answered in the next two cycles");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        proc_rvalid_o |-> proc_rdata_o == exp_rdata)
        else report_mismatch("proc_rdata_o", $sampled(exp_rdata), $sampled(proc_rdata_o));

    // In bypass mode the memory sees the processor request unchanged
    assert property (@(posedge clk) disable iff (!rst_n)
        (bypass_mode && mem_req_o) |-> mem_addr_o == proc_addr_i)
        else report_mismatch("mem_addr_o", $sampled(proc_addr_i), $sampled(mem_addr_o));
    assert property (@(posedge clk) disable iff (!rst_n)
        (bypass_mode && mem_req_o) |-> mem_we_o == proc_we_i)
        else report_mismatch("mem_we_o", $sampled(proc_we_i), $sampled(mem_we_o));
    assert property (@(posedge clk) disable iff (!rst_n)
        (bypass_mode && mem_req_o) |-> mem_be_o == proc_be_i)
        else report_mismatch("mem_be_o", $sampled(proc_be_i), $sampled(mem_be_o));
    assert property (@(posedge clk) disable iff (!rst_n)
        (bypass_mode && mem_req_o) |-> mem_wdata_o == proc_wdata_i)
        else report_mismatch("mem_wdata_o", $sampled(proc_wdata_i), $sampled(mem_wdata_o));

    assert property (@(posedge clk) disable iff (!rst_n)
        (!bypass_mode && mem_req_o) |-> mem_be_o == 4'hF)
        else report_mismatch("mem_be_o", 4'hF, $sampled(mem_be_o));

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            errors++;
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d", errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial
    begin
        errors = 0;
        cycles = 0;
        mem_reads = 0;
        mem_writes = 0;
        lfsr = 16'd44927;
        last_wr_addr = '0;
        exp_rdata = '0;
        expect_hit = 1'b0;
        bypass_mode = 1'b0;
        rst_n = 1'b0;
        proc_req_i = 1'b0;
        proc_addr_i = '0;
        proc_we_i = 1'b0;
        proc_be_i = '0;
        proc_wdata_i = '0;
        mem_gnt_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        for (int i = 0; i < 64; i++)
        begin
            mem_model[i] = fill_word(i[5:0]);
            ref_mem[i] = fill_word(i[5:0]);
        end
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        // Miss, hit, partial store hit and reload on index 4
        run_access(16'h0010, 1'b0, 4'hF, '0, 1'b0, 0, 1);
        check_csr(`CSR_MISSES, 32'd1);
        run_access(16'h0010, 1'b0, 4'hF, '0, 1'b1, 0, 0);
        check_csr(`CSR_HITS, 32'd1);
        run_access(16'h0010, 1'b1, 4'b0110, 32'hDEAD_BEEF, 1'b1, 0, 0);
        run_access(16'h0010, 1'b0, 4'hF, '0, 1'b1, 0, 0);
        check_csr(`CSR_HITS, 32'd3);

        // Same index with another tag evicts the dirty line
        run_access(16'h0050, 1'b0, 4'hF, '0, 1'b0, 1, 1);
        if (last_wr_addr !== 16'h0010)
            report_mismatch("mem_addr_o", 16'h0010, last_wr_addr);
        check_mem_word(16'h0010);
        check_csr(`CSR_WRITEBACKS, 32'd1);
        check_csr(`CSR_MISSES, 32'd2);

        // Store miss merges into the refill, then gets evicted
        run_access(16'h0024, 1'b1, 4'b1001, 32'h1234_5678, 1'b0, 0, 1);
        run_access(16'h0024, 1'b0, 4'hF, '0, 1'b1, 0, 0);
        run_access(16'h0064, 1'b0, 4'hF, '0, 1'b0, 1, 1);
        check_mem_word(16'h0024);
        check_csr(`CSR_HITS, 32'd4);
        check_csr(`CSR_MISSES, 32'd4);
        check_csr(`CSR_WRITEBACKS, 32'd2);

        apb_write(`CSR_CTRL, 32'h0000_0001);
        check_csr(`CSR_CTRL, 32'h0000_0001);
        bypass_mode = 1'b1;
        run_access(16'h0010, 1'b0, 4'hF, '0, 1'b0, 0, 1);
        run_access(16'h00C8, 1'b1, 4'b0011, 32'hCAFE_F00D, 1'b0, 1, 0);
        check_mem_word(16'h00C8);
        run_access(16'h00C8, 1'b0, 4'hF, '0, 1'b0, 0, 1);
        run_access(16'h0024, 1'b0, 4'hF, '0, 1'b0, 0, 1);
        check_csr(`CSR_HITS, 32'd4);
        check_csr(`CSR_MISSES, 32'd4);
        check_csr(`CSR_WRITEBACKS, 32'd2);
        apb_write(`CSR_CTRL, 32'h0000_0000);
        bypass_mode = 1'b0;
        check_csr(`CSR_CTRL, 32'h0000_0000);

        // The cache contents survive a bypass period
        run_access(16'h0050, 1'b0, 4'hF, '0, 1'b1, 0, 0);
        check_csr(`CSR_HITS, 32'd5);

        apb_write(`CSR_HITS, 32'hFFFF_FFFF);
        check_csr(`CSR_HITS, 32'd0);
        apb_write(`CSR_MISSES, 32'h0000_0007);
        check_csr(`CSR_MISSES, 32'd0);
        apb_write(`CSR_WRITEBACKS, 32'h8000_0001);
        check_csr(`CSR_WRITEBACKS, 32'd0);
        check_csr(8'h10, 32'd0);

        repeat (4) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+src
src/cache_pkg.sv
src/cache_line_store.sv
src/cache_ctrl_fsm.sv
src/cache_csr_apb.sv
src/dcache_top.sv
tb/tb_dcache_top.sv
